/* verification/snd_trace.txt */
# W addr data | R addr exp | M addr data | N addr exp | O rom_byte rom_addr | P mcu_rst
# C start coin joy1 joy2 service | V pulse irq_n | X we snd_addr snd_data main_addr main_data
# S amp0 amp1 cen_ticks must_toggle    (all fields hex)
W A000 06
P 1
O 5A 4123
R 8123 5A
O C3 1234
R 1234 C3
W A000 02
P 0
O 77 5FFF
R 9FFF 77
W A000 00
O 11 0123
R 8123 11
C 1 2 55 2A 1
R C000 D5
R C001 2A
R C002 FB
R C003 FF
C 2 1 0A 7F 0
R C000 0A
R C001 FF
R C002 F6
R C007 FF
M 123 A5
R D123 A5
R E123 A5
W D456 3C
N 456 3C
X 1 D010 11 020 22
X 0 D020 22 010 11
X 0 E010 11 020 22
V 0 1
V 1 0
V 0 0
W F000 00
V 0 1
W B000 03
W B001 30
W B002 05
W B003 00
R B000 03
R B001 30
S 1800 0 20 1
W B003 20
R B003 20
S 1800 1800 20 1
W B001 F0
W B003 F0
S 7800 B400 20 1
W B001 00
W B003 00
S 0 0 8 0

/* list.f */
rtl/snd_pkg.sv
rtl/snd_bus_if.sv
rtl/snd_decoder.sv
rtl/shared_ram_arb.sv
rtl/tone_gen.sv
rtl/snd_mixer.sv
rtl/snd_top.sv
verification/snd_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f list.f --top-module snd_tb -o snd_sim

./obj_dir/snd_sim | tee sim.log

if grep -q "All tests passed" sim.log; then
    echo "Simulation PASSED"
else
    echo "Simulation FAILED"
    exit 1
fi

/* verification/snd_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module snd_tb;
    import snd_pkg::*;

    localparam int ACK_LIMIT = 40;  // Longest single access in cycles

    logic        clk = 1'b0;
    logic        rst, cen, lvbl;
    logic        cpu_req, cpu_we, cpu_ack;
    snd_addr_t   cpu_addr;
    byte_t       cpu_wdata, cpu_rdata;
    logic        main_req, main_we, main_ack;
    ram_addr_t   main_addr;
    byte_t       main_wdata, main_rdata;
    logic [14:0] rom_addr;
    logic        rom_cs, rom_ok;
    byte_t       rom_data;
    logic [1:0]  start_button, coin_input;
    logic [6:0]  joystick1, joystick2;
    logic        service, mcu_rst, irq_n, peak;
    sample_t     snd;

    int          seed = 32'hacaa_bda4;
    int          check_errs = 0;
    int          timeouts = 0;
    int          other_errs = 0;
    int          trace_lines = 0;
    int          rom_wait;
    int          fd;
    string       line;
    logic [1:0]  cen_cnt;
    byte_t       rom_byte;       // Next ROM answer
    logic [14:0] rom_exp_addr;

    snd_top uut (.*);

    always #4 clk = ~clk;

    always @(negedge clk) begin
        cen_cnt <= cen_cnt + 2'd1;
        cen     <= cen_cnt == 2'd3;  // One cycle in four
    end

    // ROM answers after 0 to 3 idle cycles
    always @(negedge clk) begin
        if (rom_cs) begin
            check_rom_addr(rom_addr, rom_exp_addr);
            rom_wait = $unsigned($random(seed)) % 4;
            repeat (rom_wait) @(negedge clk);
            rom_ok   = 1'b1;
            rom_data = rom_byte;
            @(negedge clk);
            rom_ok = 1'b0;
        end
    end

    task automatic check_byte(input string what, input byte_t got, input byte_t exp);
        if (got !== exp) begin
            check_errs++;
            $display("CHECK FAILED at %0t: %s got %02h expected %02h", $time, what, got, exp);
        end
    endtask

    task automatic check_rom_addr(input logic [14:0] got, input logic [14:0] exp);
        if (got !== exp) begin
            check_errs++;
            $display("CHECK FAILED at %0t: rom_addr got %04h expected %04h", $time, got, exp);
        end
    endtask

    task automatic check_sample(input sample_t got, input sample_t exp);
        if (got !== exp) begin
            check_errs++;
            $display("CHECK FAILED at %0t: snd got %0d expected %0d", $time, got, exp);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            check_errs++;
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic snd_access(input snd_addr_t addr, input logic we, input byte_t data);
        int n;
        cpu_addr  = addr;
        cpu_we    = we;
        cpu_wdata = we ? data : 8'h00;
        cpu_req   = 1'b1;
        @(negedge clk);
        cpu_req = 1'b0;
        n = 0;
        while (!cpu_ack && n < ACK_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!cpu_ack) begin
            timeouts++;
            $display("Sound CPU access to %04h was never acknowledged", addr);
        end else if (!we) begin
            check_byte($sformatf("sound read %04h", addr), cpu_rdata, data);
        end
    endtask

    task automatic main_access(input ram_addr_t addr, input logic we, input byte_t data);
        int n;
        main_addr  = addr;
        main_we    = we;
        main_wdata = we ? data : 8'h00;
        main_req   = 1'b1;
        @(negedge clk);
        main_req = 1'b0;
        n = 0;
        while (!main_ack && n < ACK_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!main_ack) begin
            timeouts++;
            $display("Main CPU access to %03h was never acknowledged", addr);
        end else if (!we) begin
            check_byte($sformatf("main read %03h", addr), main_rdata, data);
        end
    endtask

    // Both CPUs hit the shared RAM in the same cycle
    task automatic both_access(input logic we, input snd_addr_t saddr, input byte_t sdata,
                               input ram_addr_t maddr, input byte_t mdata);
        logic s_done, m_done;
        int   n;
        cpu_addr   = saddr;
        cpu_we     = we;
        cpu_wdata  = sdata;
        main_addr  = maddr;
        main_we    = we;
        main_wdata = mdata;
        cpu_req    = 1'b1;
        main_req   = 1'b1;
        @(negedge clk);
        cpu_req  = 1'b0;
        main_req = 1'b0;
        s_done   = 1'b0;
        m_done   = 1'b0;
        n        = 0;
        while (!(s_done && m_done) && n < ACK_LIMIT) begin
            @(negedge clk);
            n++;
            if (cpu_ack) begin
                s_done = 1'b1;
                if (!we) check_byte("sound side of shared read", cpu_rdata, sdata);
            end
            if (main_ack) begin
                m_done = 1'b1;
                if (!we) check_byte("main side of shared read", main_rdata, mdata);
            end
        end
        if (!(s_done && m_done)) begin
            timeouts++;
            $display("Simultaneous RAM access was not acknowledged on both sides");
        end
    endtask

    task automatic vblank(input logic pulse, input logic exp_irq_n);
        if (pulse) begin
            lvbl = 1'b0;
            repeat (4) @(negedge clk);
            lvbl = 1'b1;
        end
        repeat (2) @(negedge clk);
        check_flag("irq_n", irq_n, exp_irq_n);
    endtask

    // amp0 and amp1 are channel levels after gain
    task automatic audio_check(input int amp0, input int amp1, input int ticks, input logic tog);
        int      sum, d, best, i, k;
        int      cand [4];
        logic    clipped [4];
        logic    moved;
        sample_t first;
        for (i = 0; i < 4; i++) begin
            sum        = ((i & 1) != 0 ? -amp0 : amp0) + ((i & 2) != 0 ? -amp1 : amp1);
            clipped[i] = sum > 32767 || sum < -32767;
            cand[i]    = clipped[i] ? (sum > 0 ? 32767 : -32767) : sum;
        end
        repeat (12) @(negedge clk);  // Three cen ticks to settle
        first = snd;
        moved = 1'b0;
        repeat (ticks * 4) begin
            @(negedge clk);
            k    = 0;
            best = 1 << 30;
            for (i = 0; i < 4; i++) begin
                d = int'(snd) - cand[i];
                if (d < 0) d = -d;
                if (d < best) begin
                    best = d;
                    k    = i;
                end
            end
            check_sample(snd, sample_t'(cand[k]));  // Nearest legal level
            check_flag("peak", peak, clipped[k]);
            if (snd !== first) moved = 1'b1;
        end
        if (tog) check_flag("snd toggling", moved, 1'b1);
    endtask

    function automatic logic is_op(input string s);
        return s.len() > 1 && s[0] != "#";
    endfunction

    task automatic run_step(input string s);
        logic [7:0]  op;
        logic [31:0] f0, f1, f2, f3, f4;
        f0 = '0;
        f1 = '0;
        f2 = '0;
        f3 = '0;
        f4 = '0;
        void'($sscanf(s, "%c %h %h %h %h %h", op, f0, f1, f2, f3, f4));
        case (op)
            "W": snd_access(f0[15:0], 1'b1, f1[7:0]);
            "R": snd_access(f0[15:0], 1'b0, f1[7:0]);
            "M": main_access(f0[10:0], 1'b1, f1[7:0]);
            "N": main_access(f0[10:0], 1'b0, f1[7:0]);
            "X": both_access(f0[0], f1[15:0], f2[7:0], f3[10:0], f4[7:0]);
            "O": begin
                rom_byte     = f0[7:0];
                rom_exp_addr = f1[14:0];
            end
            "P": check_flag("mcu_rst", mcu_rst, f0[0]);
            "C": begin
                start_button = f0[1:0];
                coin_input   = f1[1:0];
                joystick1    = f2[6:0];
                joystick2    = f3[6:0];
                service      = f4[0];
                @(negedge clk);
            end
            "V": vblank(f0[0], f1[0]);
            "S": audio_check(int'(f0), int'(f1), int'(f2), f3[0]);
            default: begin
                other_errs++;
                $display("Unknown trace opcode in line: %s", s);
            end
        endcase
    endtask

    initial begin
        rst          = 1'b1;
        cen          = 1'b0;
        cen_cnt      = 2'd0;
        lvbl         = 1'b1;
        cpu_req      = 1'b0;
        cpu_addr     = '0;
        cpu_we       = 1'b0;
        cpu_wdata    = '0;
        main_req     = 1'b0;
        main_addr    = '0;
        main_we      = 1'b0;
        main_wdata   = '0;
        rom_ok       = 1'b0;
        rom_data     = '0;
        rom_byte     = '0;
        rom_exp_addr = '0;
        start_button = '0;
        coin_input   = '0;
        joystick1    = '0;
        joystick2    = '0;
        service      = 1'b0;
        fd = $fopen("verification/snd_trace.txt", "r");
        if (fd == 0) begin
            other_errs++;
            $display("Could not open the trace file verification/snd_trace.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (is_op(line)) trace_lines++;
            end
            $fclose(fd);
            fd = $fopen("verification/snd_trace.txt", "r");
            repeat (10) @(negedge clk);
            rst = 1'b0;
            repeat (2) @(negedge clk);
            while ($fgets(line, fd) != 0) begin
                if (is_op(line)) run_step(line);
            end
            $fclose(fd);
        end
        $display("Check failures: %0d, timeouts: %0d, other errors: %0d",
                 check_errs, timeouts, other_errs);
        if (check_errs == 0 && timeouts == 0 && other_errs == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // 200 cycles per trace step
    initial begin
        wait (trace_lines > 0);
        repeat (trace_lines * 200) @(posedge clk);
        $display("The run did not finish within %0d cycles", trace_lines * 200);
        $display("Check failures: %0d, timeouts: %0d, other errors: %0d",
                 check_errs, timeouts, other_errs);
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/snd_top.sv */
`timescale 1ns/1ps
`default_nettype none

module snd_top (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 cen,
    input  wire                 lvbl,
    // Sound CPU cycles
    input  wire                 cpu_req,
    input  snd_pkg::snd_addr_t  cpu_addr,
    input  wire                 cpu_we,
    input  snd_pkg::byte_t      cpu_wdata,
    output logic                cpu_ack,
    output snd_pkg::byte_t      cpu_rdata,
    // Main CPU side of the shared RAM
    input  wire                 main_req,
    input  snd_pkg::ram_addr_t  main_addr,
    input  wire                 main_we,
    input  snd_pkg::byte_t      main_wdata,
    output logic                main_ack,
    output snd_pkg::byte_t      main_rdata,
    // ROM
    output logic [14:0]         rom_addr,
    output logic                rom_cs,
    input  wire                 rom_ok,
    input  snd_pkg::byte_t      rom_data,
    // Cabinet
    input  wire [1:0]           start_button,
    input  wire [1:0]           coin_input,
    input  wire [6:0]           joystick1,
    input  wire [6:0]           joystick2,
    input  wire                 service,
    output logic                mcu_rst,
    output logic                irq_n,
    output snd_pkg::sample_t    snd,
    output logic                peak
);
    snd_pkg::sample_t ch0, ch1;

    snd_bus_if ram_bus ();
    snd_bus_if tone_bus ();

    snd_decoder u_dec (
        .clk(clk), .rst(rst), .lvbl(lvbl),
        .cpu_req(cpu_req), .cpu_addr(cpu_addr), .cpu_we(cpu_we), .cpu_wdata(cpu_wdata),
        .cpu_ack(cpu_ack), .cpu_rdata(cpu_rdata),
        .start_button(start_button), .coin_input(coin_input),
        .joystick1(joystick1), .joystick2(joystick2), .service(service),
        .rom_addr(rom_addr), .rom_cs(rom_cs), .rom_ok(rom_ok), .rom_data(rom_data),
        .mcu_rst(mcu_rst), .irq_n(irq_n),
        .ram_bus(ram_bus.master), .tone_bus(tone_bus.master)
    );

    shared_ram_arb u_arb (
        .clk(clk), .rst(rst),
        .main_req(main_req), .main_addr(main_addr), .main_we(main_we),
        .main_wdata(main_wdata), .main_ack(main_ack), .main_rdata(main_rdata),
        .snd_bus(ram_bus.slave)
    );

    tone_gen u_tone (
        .clk(clk), .rst(rst), .cen(cen), .bus(tone_bus.slave), .ch0(ch0), .ch1(ch1)
    );

    snd_mixer u_mix (
        .clk(clk), .rst(rst), .cen(cen), .ch0(ch0), .ch1(ch1), .snd(snd), .peak(peak)
    );

endmodule

`default_nettype wire

/* rtl/snd_mixer.sv */
`timescale 1ns/1ps
`default_nettype none

module snd_mixer (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 cen,
    input  snd_pkg::sample_t    ch0,
    input  snd_pkg::sample_t    ch1,
    output snd_pkg::sample_t    snd,
    output logic                peak
);
    import snd_pkg::*;

    logic signed [24:0] scaled0, scaled1;  // 16 bit sample times 9 bit gain
    logic signed [25:0] sum;
    sample_t            sat;
    logic               clip;

    // Gains are 4.4 so the product drops four fraction bits
    assign scaled0 = (25'(ch0) * 25'($signed({1'b0, CH0_GAIN}))) >>> 4;
    assign scaled1 = (25'(ch1) * 25'($signed({1'b0, CH1_GAIN}))) >>> 4;
    assign sum     = 26'(scaled0) + 26'(scaled1);

    always_comb begin
        clip = 1'b0;
        sat  = sum[15:0];
        if (sum > SAMPLE_MAX) begin
            clip = 1'b1;
            sat  = SAMPLE_MAX;
        end else if (sum < -SAMPLE_MAX) begin
            clip = 1'b1;
            sat  = -SAMPLE_MAX;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            snd  <= '0;
            peak <= 1'b0;
        end else if (cen) begin
            snd  <= sat;
            peak <= clip;  // Tracks the latest sample only
        end
    end

endmodule

`default_nettype wire

/* rtl/tone_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tone_gen (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 cen,
    snd_bus_if.slave            bus,
    output snd_pkg::sample_t    ch0,
    output snd_pkg::sample_t    ch1
);
    import snd_pkg::*;

    // Per channel pair: period low, then {vol, period high}
    byte_t   regs [4];
    sample_t out [2];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            regs    <= '{default: '0};
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= bus.req;
            if (bus.req && bus.we) regs[bus.addr[1:0]] <= bus.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (bus.req) bus.rdata <= regs[bus.addr[1:0]];
    end

    for (genvar i = 0; i < 2; i++) begin : g_ch
        period_t period;
        vol_t    vol;
        period_t cnt;
        logic    sq;      // High for the positive half
        sample_t level;

        assign period = {regs[2*i+1][3:0], regs[2*i]};
        assign vol    = regs[2*i+1][7:4];
        assign level  = sample_t'({12'd0, vol}) * TONE_STEP;
        assign out[i] = sq ? level : -level;

        always_ff @(posedge clk or posedge rst) begin
            if (rst) begin
                cnt <= '0;
                sq  <= 1'b1;
            end else if (cen) begin
                if (period == '0) begin
                    // Stopped channel parks on its positive level
                    cnt <= '0;
                    sq  <= 1'b1;
                end else if (cnt >= period - 1'b1) begin
                    cnt <= '0;
                    sq  <= ~sq;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

    assign ch0 = out[0];
    assign ch1 = out[1];

endmodule

`default_nettype wire

/* rtl/shared_ram_arb.sv */
`timescale 1ns/1ps
`default_nettype none

module shared_ram_arb (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 main_req,
    input  snd_pkg::ram_addr_t  main_addr,
    input  wire                 main_we,
    input  snd_pkg::byte_t      main_wdata,
    output logic                main_ack,
    output snd_pkg::byte_t      main_rdata,
    snd_bus_if.slave            snd_bus
);
    import snd_pkg::*;

    byte_t      mem [SHARED_RAM_WORDS];
    arb_state_t state;
    logic       snd_pend, main_pend;
    logic       last_snd;  // Sound side won the last grant
    ram_addr_t  snd_addr_q, main_addr_q, acc_addr;
    byte_t      snd_wdata_q, main_wdata_q, acc_wdata, rd_q;
    logic       snd_we_q, main_we_q, acc_we;

    // Single array port shared by both sides
    assign acc_addr  = state == SERVE_MAIN ? main_addr_q  : snd_addr_q;
    assign acc_wdata = state == SERVE_MAIN ? main_wdata_q : snd_wdata_q;
    assign acc_we    = state == SERVE_MAIN ? main_we_q    : snd_we_q;

    assign snd_bus.rdata = rd_q;
    assign main_rdata    = rd_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= ARB_IDLE;
            snd_pend    <= 1'b0;
            main_pend   <= 1'b0;
            last_snd    <= 1'b0;
            main_ack    <= 1'b0;
            snd_bus.ack <= 1'b0;
        end else begin
            main_ack    <= 1'b0;
            snd_bus.ack <= 1'b0;
            if (snd_bus.req) snd_pend <= 1'b1;
            if (main_req) main_pend <= 1'b1;
            case (state)
                ARB_IDLE: begin
                    // On a tie the side that lost last time goes first
                    if (snd_pend && (!main_pend || !last_snd)) state <= SERVE_SND;
                    else if (main_pend) state <= SERVE_MAIN;
                end
                SERVE_SND: begin
                    snd_pend    <= 1'b0;
                    snd_bus.ack <= 1'b1;
                    last_snd    <= 1'b1;
                    state       <= main_pend ? SERVE_MAIN : ARB_IDLE;
                end
                SERVE_MAIN: begin
                    main_pend <= 1'b0;
                    main_ack  <= 1'b1;
                    last_snd  <= 1'b0;
                    state     <= snd_pend ? SERVE_SND : ARB_IDLE;
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (snd_bus.req) begin
            snd_addr_q  <= snd_bus.addr[10:0];
            snd_wdata_q <= snd_bus.wdata;
            snd_we_q    <= snd_bus.we;
        end
        if (main_req) begin
            main_addr_q  <= main_addr;
            main_wdata_q <= main_wdata;
            main_we_q    <= main_we;
        end
        if (state != ARB_IDLE) begin
            if (acc_we) mem[acc_addr] <= acc_wdata;
            rd_q <= mem[acc_addr];  // Old data on writes
        end
    end

    a_one_pending: assert property (@(posedge clk) disable iff (rst)
        !(snd_bus.req && snd_pend) && !(main_req && main_pend))
        else $error("RAM request while the same side is still pending");

    a_main_latency: assert property (@(posedge clk) disable iff (rst)
        main_req |-> ##[2:4] main_ack)
        else $error("main CPU RAM access took too long");

endmodule

`default_nettype wire

/* rtl/snd_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module snd_decoder (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 lvbl,
    input  wire                 cpu_req,
    input  snd_pkg::snd_addr_t  cpu_addr,
    input  wire                 cpu_we,
    input  snd_pkg::byte_t      cpu_wdata,
    output logic                cpu_ack,
    output snd_pkg::byte_t      cpu_rdata,
    input  wire [1:0]           start_button,
    input  wire [1:0]           coin_input,
    input  wire [6:0]           joystick1,
    input  wire [6:0]           joystick2,
    input  wire                 service,
    output logic [14:0]         rom_addr,
    output logic                rom_cs,
    input  wire                 rom_ok,
    input  snd_pkg::byte_t      rom_data,
    output logic                mcu_rst,
    output logic                irq_n,
    snd_bus_if.master           ram_bus,
    snd_bus_if.master           tone_bus
);
    import snd_pkg::*;

    dec_state_t state;
    logic [3:0] nib;
    logic       is_rom, is_ram, is_tone, is_local;
    snd_addr_t  addr_q;
    bank_t      bank;
    byte_t      local_rd, local_rd_q;
    logic       local_q;   // Local access in flight
    logic       irq_q, lvbl_q;

    assign nib      = cpu_addr[15:12];
    assign is_rom   = nib < ROM_TOP;
    assign is_tone  = nib == TONE_NIB;
    assign is_ram   = nib == RAM_NIB0 || nib == RAM_NIB1;
    assign is_local = nib == BANK_NIB || nib == CAB_NIB || nib == IRQ_NIB;

    // Both buses see the CPU cycle, only one gets the strobe
    assign ram_bus.addr   = cpu_addr;
    assign ram_bus.wdata  = cpu_wdata;
    assign ram_bus.we     = cpu_we;
    assign ram_bus.req    = cpu_req && is_ram;
    assign tone_bus.addr  = cpu_addr;
    assign tone_bus.wdata = cpu_wdata;
    assign tone_bus.we    = cpu_we;
    assign tone_bus.req   = cpu_req && is_tone;

    always_comb begin
        rom_addr = addr_q[14:0];
        if (addr_q[15]) rom_addr[14:13] = bank;  // Upper half is banked
    end

    always_comb begin
        local_rd = 8'hFF;  // Bank and IRQ reads float high
        if (nib == CAB_NIB) begin
            case (cpu_addr[2:0])
                3'd0:    local_rd = {start_button[0], joystick1};
                3'd1:    local_rd = {start_button[1], joystick2};
                3'd2:    local_rd = {4'hF, coin_input, 1'b1, service};
                default: local_rd = 8'hFF;
            endcase
        end
    end

    assign irq_n = ~irq_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= IDLE;
            rom_cs  <= 1'b0;
            cpu_ack <= 1'b0;
            local_q <= 1'b0;
            bank    <= '0;
            mcu_rst <= 1'b0;
            irq_q   <= 1'b0;
            lvbl_q  <= 1'b1;  // No false edge out of reset
        end else begin
            rom_cs  <= 1'b0;
            cpu_ack <= 1'b0;
            local_q <= cpu_req && is_local;
            lvbl_q  <= lvbl;
            if (cpu_req && cpu_we && nib == BANK_NIB) begin
                bank    <= cpu_wdata[1:0];
                mcu_rst <= cpu_wdata[2];
            end
            // A new vblank edge wins over a same cycle acknowledge
            if (lvbl_q && !lvbl) irq_q <= 1'b1;
            else if (cpu_req && cpu_we && nib == IRQ_NIB) irq_q <= 1'b0;
            if (local_q || tone_bus.ack) cpu_ack <= 1'b1;
            case (state)
                IDLE: begin
                    if (cpu_req && is_rom) begin
                        rom_cs <= 1'b1;
                        state  <= WAIT_ROM;
                    end else if (cpu_req && is_ram) begin
                        state <= WAIT_RAM;
                    end
                end
                WAIT_ROM: if (rom_ok) begin
                    cpu_ack <= 1'b1;
                    state   <= IDLE;
                end
                WAIT_RAM: if (ram_bus.ack) begin
                    cpu_ack <= 1'b1;
                    state   <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cpu_req) begin
            addr_q     <= cpu_addr;
            local_rd_q <= local_rd;  // Inputs sampled at the request
        end
        if (local_q) cpu_rdata <= local_rd_q;
        else if (tone_bus.ack) cpu_rdata <= tone_bus.rdata;
        else if (state == WAIT_ROM && rom_ok) cpu_rdata <= rom_data;
        else if (state == WAIT_RAM && ram_bus.ack) cpu_rdata <= ram_bus.rdata;
    end

    a_one_outstanding: assert property (@(posedge clk) disable iff (rst)
        cpu_req |-> state == IDLE && !local_q)
        else $error("sound CPU request while a cycle is in flight");

endmodule

`default_nettype wire

/* rtl/snd_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface snd_bus_if;
    import snd_pkg::*;

    snd_addr_t addr;
    byte_t     wdata;
    logic      we;
    logic      req;    // One cycle strobe
    byte_t     rdata;  // Valid with ack on reads
    logic      ack;

    modport master (
        output addr,
        output wdata,
        output we,
        output req,
        input  rdata,
        input  ack
    );

    modport slave (
        input  addr,
        input  wdata,
        input  we,
        input  req,
        output rdata,
        output ack
    );

endinterface

`default_nettype wire

/* rtl/snd_pkg.sv */
`default_nettype none

package snd_pkg;

    // Bus and storage widths
    typedef logic [15:0]        snd_addr_t;
    typedef logic [7:0]         byte_t;
    typedef logic [10:0]        ram_addr_t;
    typedef logic [1:0]         bank_t;

    // Audio widths
    typedef logic [11:0]        period_t;   // Half period in cen ticks
    typedef logic [3:0]         vol_t;
    typedef logic [7:0]         gain_t;     // 4.4 fixed point
    typedef logic signed [15:0] sample_t;

    // Sound address map, upper nibble
    localparam logic [3:0] ROM_TOP  = 4'hA;  // Everything below is ROM
    localparam logic [3:0] BANK_NIB = 4'hA;
    localparam logic [3:0] TONE_NIB = 4'hB;
    localparam logic [3:0] CAB_NIB  = 4'hC;
    localparam logic [3:0] RAM_NIB0 = 4'hD;
    localparam logic [3:0] RAM_NIB1 = 4'hE;  // Mirror of RAM_NIB0
    localparam logic [3:0] IRQ_NIB  = 4'hF;

    // Audio constants
    localparam sample_t TONE_STEP  = 16'sd2048;
    localparam sample_t SAMPLE_MAX = 16'sd32767;  // Symmetric clip level
    localparam gain_t   CH0_GAIN   = 8'h10;       // 1.0
    localparam gain_t   CH1_GAIN   = 8'h18;       // 1.5

    localparam int SHARED_RAM_WORDS = 2048;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_ROM,
        WAIT_RAM
    } dec_state_t;

    // Arbiter states carry a prefix so they do not clash with the decoder
    typedef enum logic [1:0] {
        ARB_IDLE,
        SERVE_SND,
        SERVE_MAIN
    } arb_state_t;

endpackage

`default_nettype wire
